// File: build.f
design/ids_pkt_pkg.sv
design/ids_reg_pkg.sv
design/ids_pkt_fsm.sv
design/ids_pkt_buffer.sv
design/ids_regs.sv
design/ids_top.sv
tb/tb_ids.sv

// File: tb/tb_ids.sv
`default_nettype none

module tb_ids
   import ids_pkt_pkg::*, ids_reg_pkg::*;
();

   localparam int NUM_PKTS = 14;
   localparam int MAX_LEN  = 40;
   localparam int CLK_PER  = 4;
   // 200 cycles per packet, plus room for reset and idle checks
   localparam int TIMEOUT  = NUM_PKTS * 200 * CLK_PER + 2000 * CLK_PER;

   logic      clk;
   logic      reset;
   pkt_word_t in_word;
   logic      in_wr;
   logic      in_rdy;
   pkt_word_t out_word;
   logic      out_wr;
   logic      out_rdy;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;

   logic [31:0] seed;
   int          val_errs;
   int          proto_errs;
   int          words_seen;
   buf_idx_t    start_idx;

   // current packet and its edits
   pkt_word_t   sent     [MAX_LEN];
   logic        edit_en  [MAX_LEN];
   field_t      edit_val [MAX_LEN];
   // words still owed by the DUT
   pkt_word_t   exp_q [$];
   pkt_word_t   exp_w;

   ids_top dut (
      .clk        (clk),
      .reset      (reset),
      .in_word_i  (in_word),
      .in_wr_i    (in_wr),
      .in_rdy_o   (in_rdy),
      .out_word_o (out_word),
      .out_wr_o   (out_wr),
      .out_rdy_i  (out_rdy),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .paddr_i    (paddr),
      .pwdata_i   (pwdata),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr)
   );

   always #(CLK_PER / 2) clk = ~clk;

   ////////////////////
   // helpers
   ////////////////////
   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // expected output word, field replaced only when edited
   function automatic pkt_word_t ref_word(input pkt_word_t w, input logic edited,
                                          input field_t f);
      pkt_word_t r;
      r = w;
      if (edited) begin
         r.data[FIELD_LSB +: FIELD_W] = f;
      end
      return r;
   endfunction

   // state code low, read pointer in byte 1
   function automatic apb_data_t status_value(input logic [2:0] code, input buf_idx_t ptr);
      return {16'h0000, ptr, 5'b00000, code};
   endfunction

   // bit 11 low selects the window, index in bits 9:2
   function automatic apb_addr_t window_addr(input buf_idx_t idx);
      return apb_addr_t'({idx, 2'b00});
   endfunction

   ////////////////////
   // compare tasks
   ////////////////////
   task automatic check_word(input string name, input pkt_word_t got, input pkt_word_t exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         val_errs++;
      end
   endtask

   task automatic check_field(input string name, input field_t got, input field_t exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         val_errs++;
      end
   endtask

   task automatic check_status(input string name, input apb_data_t got, input apb_data_t exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         val_errs++;
      end
   endtask

   task automatic check_err(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         val_errs++;
      end
   endtask

   ////////////////////
   // apb master
   ////////////////////
   // setup, access, then wait for pready at the falling edge
   task automatic apb_transfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                               output apb_data_t rdata, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      while (!pready) begin
         @(negedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
      apb_transfer(addr, 1'b0, '0, rdata, err);
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic err);
      apb_data_t unused;
      apb_transfer(addr, 1'b1, wdata, unused, err);
   endtask

   // poll status until the state code shows up
   task automatic wait_for_state(input logic [2:0] code, output apb_data_t st);
      logic err;
      apb_read(REG_STATUS_ADDR, st, err);
      while (st[2:0] != code) begin
         apb_read(REG_STATUS_ADDR, st, err);
      end
   endtask

   ////////////////////
   // packet stimulus
   ////////////////////
   // header and end get a nonzero ctrl byte, body words zero
   task automatic build_packet(input int len);
      logic [31:0] r;
      for (int i = 0; i < len; i++) begin
         r = next_rand();
         sent[i].data[63:32] = r;
         r = next_rand();
         sent[i].data[31:0] = r;
         r = next_rand();
         if (i == 0 || i == len - 1) begin
            sent[i].ctrl = (r[31:24] == 8'h00) ? 8'h01 : r[31:24];
         end else begin
            sent[i].ctrl = 8'h00;
         end
         edit_en[i]  = 1'b0;
         edit_val[i] = '0;
      end
   endtask

   task automatic send_packet(input int len);
      for (int i = 0; i < len; i++) begin
         @(posedge clk);
         in_word <= sent[i];
         in_wr   <= 1'b1;
         // taken on the next rising edge once ready
         @(negedge clk);
         while (!in_rdy) begin
            @(negedge clk);
         end
      end
      @(posedge clk);
      in_wr   <= 1'b0;
      in_word <= '0;
   endtask

   // window, release and decode behavior with no packet held
   task automatic idle_checks();
      apb_data_t rd;
      logic      err;
      apb_read(window_addr(8'h05), rd, err);
      check_err("pslverr_o", err, 1'b1);
      check_status("prdata_o", rd, '0);
      apb_write(window_addr(8'h05), 32'h0000_abcd, err);
      check_err("pslverr_o", err, 1'b1);
      apb_write(REG_RELEASE_ADDR, 32'h1, err);
      check_err("pslverr_o", err, 1'b0);
      // a stray output word here gets flagged by the compare process
      repeat (20) @(posedge clk);
      apb_read(REG_STATUS_ADDR, rd, err);
      check_status("status", rd, status_value(3'd0, start_idx));
      apb_read(12'h808, rd, err);
      check_err("pslverr_o", err, 1'b0);
      check_status("prdata_o", rd, '0);
   endtask

   task automatic run_packet(input int p);
      int          len;
      logic [31:0] r;
      apb_data_t   rd;
      logic        err;
      logic        edits;
      logic        rand_rdy;
      r        = next_rand();
      len      = 3 + int'(r[31:16] % 38);
      // first packets plain, then edits, then random back-pressure
      edits    = (p >= 3);
      rand_rdy = (p >= 6);
      out_rdy <= 1'b1;
      build_packet(len);
      send_packet(len);
      wait_for_state(3'd7, rd);
      check_status("status", rd, status_value(3'd7, start_idx));
      @(negedge clk);
      check_err("in_rdy_o", in_rdy, 1'b0);
      for (int i = 0; i < len; i++) begin
         r = next_rand();
         if (i == 0 || r[31]) begin
            apb_read(window_addr(buf_idx_t'(start_idx + i)), rd, err);
            check_err("pslverr_o", err, 1'b0);
            check_field("prdata_o", rd[15:0], sent[i].data[FIELD_LSB +: FIELD_W]);
         end
         if (edits && r[30]) begin
            edit_en[i]  = 1'b1;
            edit_val[i] = r[23:8];
            apb_write(window_addr(buf_idx_t'(start_idx + i)), {16'h0000, r[23:8]}, err);
            check_err("pslverr_o", err, 1'b0);
         end
      end
      for (int i = 0; i < len; i++) begin
         exp_q.push_back(ref_word(sent[i], edit_en[i], edit_val[i]));
      end
      apb_write(REG_RELEASE_ADDR, 32'h1, err);
      check_err("pslverr_o", err, 1'b0);
      // drain, a lost word ends in the watchdog
      while (exp_q.size() != 0) begin
         @(posedge clk);
         r = next_rand();
         out_rdy <= rand_rdy ? r[31] : 1'b1;
      end
      wait_for_state(3'd0, rd);
      check_status("status", rd, status_value(3'd0, buf_idx_t'(start_idx + len)));
      start_idx = buf_idx_t'(start_idx + len);
   endtask

   ////////////////////
   // output compare
   ////////////////////
   always @(negedge clk) begin
      if (!reset && out_wr) begin
         if (exp_q.size() == 0) begin
            $display("output word %h appeared with no word expected", out_word);
            proto_errs++;
         end else begin
            exp_w = exp_q.pop_front();
            check_word("out_word_o", out_word, exp_w);
            words_seen++;
         end
      end
   end

   // watchdog
   initial begin
      #(TIMEOUT);
      $display("timeout: the run did not finish in the expected time");
      $display("CHECKS FAILED");
      $finish;
   end

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      clk        = 1'b0;
      reset      = 1'b1;
      in_word    = '0;
      in_wr      = 1'b0;
      out_rdy    = 1'b1;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      seed       = 32'hf8096993;
      val_errs   = 0;
      proto_errs = 0;
      words_seen = 0;
      start_idx  = '0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_err("in_rdy_o", in_rdy, 1'b1);
      idle_checks();
      for (int p = 0; p < NUM_PKTS; p++) begin
         run_packet(p);
      end
      // again with the read pointer away from zero
      idle_checks();
      $display("summary: %0d value errors, %0d other errors, %0d words compared",
               val_errs, proto_errs, words_seen);
      if (val_errs == 0 && proto_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: design/ids_top.sv
`default_nettype none

module ids_top
   import ids_pkt_pkg::*, ids_reg_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset,
   // packet in
   input  wire pkt_word_t in_word_i,
   input  wire logic      in_wr_i,
   output logic           in_rdy_o,
   // packet out
   output pkt_word_t      out_word_o,
   output logic           out_wr_o,
   input  wire logic      out_rdy_i,
   // apb
   input  wire logic      psel_i,
   input  wire logic      penable_i,
   input  wire logic      pwrite_i,
   input  wire apb_addr_t paddr_i,
   input  wire apb_data_t pwdata_i,
   output apb_data_t      prdata_o,
   output logic           pready_o,
   output logic           pslverr_o
);

   // fsm to buffer
   logic         accept;
   logic         last;
   logic         hold;
   logic         drain;
   // buffer back to fsm and regs
   logic         room;
   logic         drained;
   buf_idx_t     rd_ptr;
   frame_state_t state;
   // software side
   edit_req_t    edit_req;
   edit_rsp_t    edit_rsp;
   logic         release_w;

   ids_pkt_fsm u_fsm (
      .clk       (clk),
      .reset     (reset),
      .in_wr_i   (in_wr_i),
      .in_ctrl_i (in_word_i.ctrl),
      .room_i    (room),
      .drained_i (drained),
      .release_i (release_w),
      .in_rdy_o  (in_rdy_o),
      .accept_o  (accept),
      .last_o    (last),
      .hold_o    (hold),
      .drain_o   (drain),
      .state_o   (state)
   );

   ids_pkt_buffer u_buffer (
      .clk        (clk),
      .reset      (reset),
      .in_word_i  (in_word_i),
      .accept_i   (accept),
      .last_i     (last),
      .hold_i     (hold),
      .drain_i    (drain),
      .out_rdy_i  (out_rdy_i),
      .edit_req_i (edit_req),
      .room_o     (room),
      .drained_o  (drained),
      .rd_ptr_o   (rd_ptr),
      .edit_rsp_o (edit_rsp),
      .out_word_o (out_word_o),
      .out_wr_o   (out_wr_o)
   );

   ids_regs u_regs (
      .clk        (clk),
      .reset      (reset),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .state_i    (state),
      .rd_ptr_i   (rd_ptr),
      .edit_req_o (edit_req),
      .edit_rsp_i (edit_rsp),
      .release_o  (release_w)
   );

endmodule

`default_nettype wire

// File: design/ids_regs.sv
`default_nettype none

module ids_regs
   import ids_pkt_pkg::*, ids_reg_pkg::*;
(
   input  wire logic         clk,
   input  wire logic         reset,
   // apb slave
   input  wire logic         psel_i,
   input  wire logic         penable_i,
   input  wire logic         pwrite_i,
   input  wire apb_addr_t    paddr_i,
   input  wire apb_data_t    pwdata_i,
   output apb_data_t         prdata_o,
   output logic              pready_o,
   output logic              pslverr_o,
   // status sources
   input  wire frame_state_t state_i,
   input  wire buf_idx_t     rd_ptr_i,
   // buffer edit port
   output edit_req_t         edit_req_o,
   input  wire edit_rsp_t    edit_rsp_i,
   output logic              release_o
);

   logic      access;
   logic      win_sel;
   logic      stat_sel;
   logic      rel_sel;
   logic      pend_q;
   apb_data_t status_w;

   // access phase only
   assign access   = psel_i && penable_i;
   assign win_sel  = !paddr_i[REG_WINDOW_BIT];
   assign stat_sel = (paddr_i == REG_STATUS_ADDR);
   assign rel_sel  = (paddr_i == REG_RELEASE_ADDR);

   ////////////////////
   // edit request
   ////////////////////
   // one request per window access with pend_q masking the wait cycle
   always_comb begin
      edit_req_o.valid  = access && win_sel && !pend_q;
      edit_req_o.write  = pwrite_i;
      edit_req_o.index  = paddr_i[BUF_IDX_W+1:2];
      edit_req_o.wfield = pwdata_i[FIELD_W-1:0];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pend_q <= 1'b0;
      end else if (edit_rsp_i.done) begin
         pend_q <= 1'b0;
      end else if (edit_req_o.valid) begin
         pend_q <= 1'b1;
      end
   end

   ////////////////////
   // transfer completion
   ////////////////////
   // window waits for the buffer while other addresses are zero wait
   assign pready_o  = access && (win_sel ? edit_rsp_i.done : 1'b1);
   assign pslverr_o = access && win_sel && edit_rsp_i.err;

   // release ignored by the FSM unless holding
   assign release_o = access && pwrite_i && rel_sel && pwdata_i[0];

   // state code low and read pointer in the second byte
   always_comb begin
      status_w        = '0;
      status_w[2:0]   = state_i;
      status_w[15:8]  = rd_ptr_i;
   end

   // read data mux
   always_comb begin
      prdata_o = '0;
      if (!pwrite_i) begin
         if (win_sel) begin
            // refused reads give zero
            if (edit_rsp_i.done && !edit_rsp_i.err) begin
               prdata_o[FIELD_W-1:0] = edit_rsp_i.rfield;
            end
         end else if (stat_sel) begin
            prdata_o = status_w;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/ids_pkt_buffer.sv
`default_nettype none

module ids_pkt_buffer
   import ids_pkt_pkg::*, ids_reg_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire pkt_word_t in_word_i,
   // control from the FSM
   input  wire logic      accept_i,
   input  wire logic      last_i,
   input  wire logic      hold_i,
   input  wire logic      drain_i,
   input  wire logic      out_rdy_i,
   // software field access
   input  wire edit_req_t edit_req_i,
   output logic           room_o,
   output logic           drained_o,
   output buf_idx_t       rd_ptr_o,
   output edit_rsp_t      edit_rsp_o,
   output pkt_word_t      out_word_o,
   output logic           out_wr_o
);

   ////////////////////
   // storage
   ////////////////////
   // field bits apart from ctrl plus low data bits
   field_t                          field_mem [BUF_DEPTH];
   logic [PKT_CTRL_W+FIELD_LSB-1:0] rest_mem  [BUF_DEPTH];

   // input register
   pkt_word_t in_word_q;
   logic      in_vld_q;
   logic      in_last_q;

   buf_idx_t  wr_ptr_q;
   buf_idx_t  rd_ptr_q;
   buf_idx_t  head_q;
   buf_cnt_t  cnt_q;

   logic      rd_en;
   logic      out_wr_q;
   field_t    field_q;
   logic [PKT_CTRL_W+FIELD_LSB-1:0] rest_q;

   // edit side
   logic      hold_ok;
   logic      edit_go;
   logic      edit_pend_q;
   logic      fm_we;
   buf_idx_t  fm_waddr;
   field_t    fm_wdata;
   buf_idx_t  fm_raddr;

   // read toward downstream only while draining
   assign rd_en     = drain_i && out_rdy_i && (rd_ptr_q != head_q);
   assign drained_o = (rd_ptr_q == head_q);
   assign room_o    = (cnt_q <= buf_cnt_t'(BUF_DEPTH - BUF_ROOM_MIN));
   assign rd_ptr_o  = rd_ptr_q;

   // last word still in flight right after hold starts
   assign hold_ok = hold_i && !in_vld_q;
   assign edit_go = edit_req_i.valid && hold_ok;

   ////////////////////
   // field memory port mux
   ////////////////////
   // incoming words win, edits only land once the packet is stored
   assign fm_we    = in_vld_q || (edit_go && edit_req_i.write);
   assign fm_waddr = in_vld_q ? wr_ptr_q : edit_req_i.index;
   assign fm_wdata = in_vld_q ? in_word_q.data[FIELD_LSB +: FIELD_W] : edit_req_i.wfield;
   assign fm_raddr = hold_i ? edit_req_i.index : rd_ptr_q;

   always_ff @(posedge clk) begin
      if (fm_we) begin
         field_mem[fm_waddr] <= fm_wdata;
      end
      if (in_vld_q) begin
         rest_mem[wr_ptr_q] <= {in_word_q.ctrl, in_word_q.data[FIELD_LSB-1:0]};
      end
      // one cycle read latency on both memories
      if (rd_en || edit_go) begin
         field_q <= field_mem[fm_raddr];
      end
      if (rd_en) begin
         rest_q <= rest_mem[rd_ptr_q];
      end
   end

   // payload of the input register
   always_ff @(posedge clk) begin
      if (accept_i) begin
         in_word_q <= in_word_i;
      end
   end

   ////////////////////
   // pointers and count
   ////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         in_vld_q    <= 1'b0;
         in_last_q   <= 1'b0;
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         head_q      <= '0;
         cnt_q       <= '0;
         out_wr_q    <= 1'b0;
         edit_pend_q <= 1'b0;
      end else begin
         in_vld_q    <= accept_i;
         in_last_q   <= last_i;
         out_wr_q    <= rd_en;
         edit_pend_q <= edit_go;
         if (in_vld_q) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         // head moves past the packet once its end is written
         if (in_vld_q && in_last_q) begin
            head_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (in_vld_q && !rd_en) begin
            cnt_q <= cnt_q + 1'b1;
         end else if (!in_vld_q && rd_en) begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

   // rebuild the word around the field
   assign out_word_o = pkt_word_t'({rest_q[PKT_CTRL_W+FIELD_LSB-1:FIELD_LSB], field_q,
                                    rest_q[FIELD_LSB-1:0]});
   assign out_wr_o   = out_wr_q;

   // accepted edits finish a cycle later, refused ones at once
   assign edit_rsp_o.done   = edit_pend_q || (edit_req_i.valid && !hold_ok);
   assign edit_rsp_o.err    = edit_req_i.valid && !hold_ok;
   assign edit_rsp_o.rfield = field_q;

endmodule

`default_nettype wire

// File: design/ids_pkt_fsm.sv
`default_nettype none

module ids_pkt_fsm
   import ids_pkt_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset,
   // upstream handshake
   input  wire logic      in_wr_i,
   input  wire pkt_ctrl_t in_ctrl_i,
   // buffer status
   input  wire logic      room_i,
   input  wire logic      drained_i,
   // software release
   input  wire logic      release_i,
   output logic           in_rdy_o,
   output logic           accept_o,
   output logic           last_o,
   output logic           hold_o,
   output logic           drain_o,
   output frame_state_t   state_o
);

   frame_state_t state_q;
   frame_state_t state_d;
   logic         ctrl_set;
   logic         taking;

   assign ctrl_set = (in_ctrl_i != '0);

   // input only while a packet is being framed
   assign taking = (state_q == FRAME_IDLE) || (state_q == FRAME_HEADER) ||
                   (state_q == FRAME_PAYLOAD);
   assign in_rdy_o = taking && room_i;

   // idle words without a header byte are not stored
   assign accept_o = in_wr_i && in_rdy_o && (ctrl_set || (state_q != FRAME_IDLE));
   assign last_o   = accept_o && ctrl_set && (state_q == FRAME_PAYLOAD);

   assign hold_o  = (state_q == FRAME_HOLD);
   assign drain_o = (state_q == FRAME_DRAIN);
   assign state_o = state_q;

   ////////////////////
   // next state
   ////////////////////
   always_comb begin
      state_d = state_q;
      case (state_q)
         FRAME_IDLE: begin
            // accept in idle implies a header byte
            if (accept_o) begin
               state_d = FRAME_HEADER;
            end
         end
         FRAME_HEADER: begin
            // first zero byte opens the body
            if (accept_o && !ctrl_set) begin
               state_d = FRAME_PAYLOAD;
            end
         end
         FRAME_PAYLOAD: begin
            if (last_o) begin
               state_d = FRAME_HOLD;
            end
         end
         FRAME_HOLD: begin
            if (release_i) begin
               state_d = FRAME_DRAIN;
            end
         end
         FRAME_DRAIN: begin
            // back to idle once read pointer meets head
            if (drained_i) begin
               state_d = FRAME_IDLE;
            end
         end
         default: begin
            state_d = FRAME_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= FRAME_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

`default_nettype wire

// File: design/ids_reg_pkg.sv
`default_nettype none

package ids_reg_pkg;

   import ids_pkt_pkg::*;

   ////////////////////
   // apb bus widths
   ////////////////////
   localparam int APB_ADDR_W = 12;
   localparam int APB_DATA_W = 32;

   typedef logic [APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [APB_DATA_W-1:0] apb_data_t;

   ////////////////////
   // register map
   ////////////////////
   // low bit 11 selects the buffer window, index in paddr[9:2]
   localparam int        REG_WINDOW_BIT   = 11;
   // state in [2:0], read pointer in [15:8]
   localparam apb_addr_t REG_STATUS_ADDR  = 12'h800;
   // bit 0 set ends the hold
   localparam apb_addr_t REG_RELEASE_ADDR = 12'h804;

   // one-shot field access toward the buffer
   typedef struct packed {
      logic     valid;
      logic     write;
      buf_idx_t index;
      field_t   wfield;
   } edit_req_t;

   // answer from the buffer, err when not holding
   typedef struct packed {
      logic   done;
      logic   err;
      field_t rfield;
   } edit_rsp_t;

endpackage

`default_nettype wire

// File: design/ids_pkt_pkg.sv
`default_nettype none

package ids_pkt_pkg;

   ////////////////////
   // packet word layout
   ////////////////////
   localparam int PKT_DATA_W = 64;
   localparam int PKT_CTRL_W = 8;

   // editable field sits in the top 16 data bits
   localparam int FIELD_LSB = 48;
   localparam int FIELD_W   = 16;

   ////////////////////
   // buffer geometry
   ////////////////////
   localparam int BUF_IDX_W    = 8;
   localparam int BUF_DEPTH    = 256;
   // keep two slots free before taking another word
   localparam int BUF_ROOM_MIN = 2;

   typedef logic [PKT_DATA_W-1:0] pkt_data_t;
   typedef logic [PKT_CTRL_W-1:0] pkt_ctrl_t;
   typedef logic [BUF_IDX_W-1:0]  buf_idx_t;
   typedef logic [BUF_IDX_W:0]    buf_cnt_t;
   typedef logic [FIELD_W-1:0]    field_t;

   // ctrl in the upper byte and data below
   typedef struct packed {
      pkt_ctrl_t ctrl;
      pkt_data_t data;
   } pkt_word_t;

   // hold sits at code 7 away from the framing codes
   typedef enum logic [2:0] {
      FRAME_IDLE    = 3'd0,
      FRAME_HEADER  = 3'd1,
      FRAME_PAYLOAD = 3'd2,
      FRAME_DRAIN   = 3'd3,
      FRAME_HOLD    = 3'd7
   } frame_state_t;

endpackage

`default_nettype wire
